// ==== common/boardPkg.sv ====
`default_nettype none

package boardPkg;

   typedef logic [31:0] dataWord;
   typedef logic [3:0]  addrWord;
   typedef logic [3:0]  selCode;

   localparam int sampleDivide = 16;
   localparam int scanDivide   = 4;
   localparam int sampleCntWidth = $clog2(sampleDivide);
   localparam int scanCntWidth   = $clog2(scanDivide);

   localparam addrWord portAAddr   = 4'd0;
   localparam addrWord portBAddr   = 4'd1;
   localparam addrWord portCAddr   = 4'd2;
   localparam addrWord portDAddr   = 4'd3;
   localparam addrWord clkTestAddr = 4'd4; // first read-only register
   localparam addrWord portIAddr   = 4'd5;
   localparam addrWord portJAddr   = 4'd6; // highest valid address

   typedef struct packed {
      logic        btnC;
      logic        btnU;
      logic        btnD;
      logic        btnL;
      logic        btnR;
      logic [15:0] switches;
   } panelIn;

   typedef struct packed {
      logic    psel;
      logic    penable;
      logic    pwrite;
      addrWord paddr;
      dataWord pwdata;
   } apbReq;

   typedef struct packed {
      dataWord prdata;
      logic    pready;
      logic    pslverr;
   } apbRsp;

   typedef struct packed {
      dataWord portA;
      dataWord portB;
      dataWord portC;
      dataWord portD;
      dataWord clkTest;
   } portState;

   typedef enum logic {
      scanIdle,
      scanRun
   } scanState;

   // button field zero-extended as seen on portI, btnR in bit 0
   function automatic dataWord buttonWord(input panelIn p);
      return {27'd0, p.btnC, p.btnU, p.btnD, p.btnL, p.btnR};
   endfunction

endpackage

`default_nettype wire

// ==== logic/tickGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tickGen import boardPkg::*;
(
   input  logic selected_clk,
   input  logic res,
   output logic sampleTick,
   output logic scanTick
);

   logic [sampleCntWidth-1:0] sampleCnt;
   logic [scanCntWidth-1:0]   scanCnt;

   assign sampleTick = (sampleCnt == '0);
   assign scanTick   = (scanCnt == '0);

   always_ff @(posedge selected_clk, posedge res)
   begin
      if (res)
      begin
         sampleCnt <= sampleCntWidth'(sampleDivide - 1);
         scanCnt   <= scanCntWidth'(scanDivide - 1);
      end
      else
      begin
         if (sampleTick)
            sampleCnt <= sampleCntWidth'(sampleDivide - 1); // reload
         else
            sampleCnt <= sampleCnt - 1'b1;

         if (scanTick)
            scanCnt <= scanCntWidth'(scanDivide - 1);
         else
            scanCnt <= scanCnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/inputSampler.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputSampler import boardPkg::*;
(
   input  logic   selected_clk,
   input  logic   res,
   input  logic   sampleTick,
   input  panelIn panelRaw,
   output panelIn panel
);

   panelIn syncA;
   panelIn syncB;

   // two flops per bit against metastability
   always_ff @(posedge selected_clk, posedge res)
   begin
      if (res)
      begin
         syncA <= '0;
         syncB <= '0;
      end
      else
      begin
         syncA <= panelRaw;
         syncB <= syncA;
      end
   end

   // slow sampling of the panel, like the old 100 Hz button clock
   always_ff @(posedge selected_clk, posedge res)
   begin
      if (res)
         panel <= '0;
      else if (sampleTick)
         panel <= syncB;
   end

endmodule

`default_nettype wire

// ==== ports/portRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module portRegs import boardPkg::*;
(
   input  logic     selected_clk,
   input  logic     res,
   input  apbReq    req,
   output apbRsp    rsp,
   input  panelIn   panel,
   output portState ports
);

   logic    access;
   logic    badAddr;
   logic    readOnly;
   logic    errFlag;
   logic    doWrite;
   dataWord readData;

   assign access   = req.psel & req.penable;
   assign badAddr  = (req.paddr > portJAddr);
   assign readOnly = req.pwrite & (req.paddr >= clkTestAddr); // clkTest, portI, portJ
   assign errFlag  = access & (badAddr | readOnly);
   assign doWrite  = access & req.pwrite & ~errFlag;

   always_comb
   begin
      case (req.paddr)
         portAAddr:   readData = ports.portA;
         portBAddr:   readData = ports.portB;
         portCAddr:   readData = ports.portC;
         portDAddr:   readData = ports.portD;
         clkTestAddr: readData = ports.clkTest;
         portIAddr:   readData = buttonWord(panel);
         portJAddr:   readData = {16'd0, panel.switches};
         default:     readData = '0;
      endcase
   end

   assign rsp = '{prdata: readData, pready: 1'b1, pslverr: errFlag}; // no wait states

   always_ff @(posedge selected_clk, posedge res)
   begin
      if (res)
         ports <= '0;
      else
      begin
         ports.clkTest <= ports.clkTest + 32'd1; // free running
         if (doWrite)
         begin
            case (req.paddr)
               portAAddr: ports.portA <= req.pwdata;
               portBAddr: ports.portB <= req.pwdata;
               portCAddr: ports.portC <= req.pwdata;
               portDAddr: ports.portD <= req.pwdata;
               default:   ;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== display/displayDriver.sv ====
`timescale 1ns/1ps
`default_nettype none

module displayDriver import boardPkg::*;
(
   input  logic       selected_clk,
   input  logic       res,
   input  logic       scanTick,
   input  portState   ports,
   input  panelIn     panel,
   output logic [7:0] seg,
   output logic [7:0] an
);

   selCode   dispSel;
   dataWord  dispWord;
   scanState state;
   logic [2:0] digit;
   logic [2:0] nextDigit;
   logic [3:0] nibble;

   // gfedcba, active low
   function automatic logic [6:0] hexToSeg(input logic [3:0] hex);
      logic [6:0] lit;
      case (hex)
         4'h0: lit = 7'h3f;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5b;
         4'h3: lit = 7'h4f;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6d;
         4'h6: lit = 7'h7d;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7f;
         4'h9: lit = 7'h6f;
         4'ha: lit = 7'h77;
         4'hb: lit = 7'h7c;
         4'hc: lit = 7'h39;
         4'hd: lit = 7'h5e;
         4'he: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;
   endfunction

   assign dispSel = panel.switches[11:8];

   always_comb
   begin
      case (dispSel)
         4'd0:    dispWord = ports.portA;
         4'd1:    dispWord = ports.portB;
         4'd2:    dispWord = ports.portC;
         4'd3:    dispWord = ports.portD;
         4'd4:    dispWord = ports.clkTest;
         4'd5:    dispWord = buttonWord(panel);
         4'd6:    dispWord = {16'd0, panel.switches};
         default: dispWord = '0;
      endcase
   end

   assign nextDigit = (state == scanIdle) ? 3'd0 : digit + 3'd1; // wraps after digit 7
   assign nibble    = dispWord[{nextDigit, 2'b00} +: 4];

   always_ff @(posedge selected_clk, posedge res)
   begin
      if (res)
      begin
         state <= scanIdle;
         digit <= 3'd0;
         an    <= 8'hff; // all digits dark
         seg   <= 8'hff;
      end
      else if (scanTick)
      begin
         state <= scanRun;
         digit <= nextDigit;
         an    <= ~(8'd1 << nextDigit);
         seg   <= {1'b1, hexToSeg(nibble)}; // dp off
      end
   end

endmodule

`default_nettype wire

// ==== logic/boardTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module boardTop import boardPkg::*;
(
   input  logic        selected_clk,
   input  logic        res,
   input  panelIn      panelRaw,
   input  apbReq       req,
   output apbRsp       rsp,
   output logic [15:0] leds,
   output logic [7:0]  seg,
   output logic [7:0]  an
);

   logic     sampleTick;
   logic     scanTick;
   panelIn   panel;
   portState ports;

   tickGen tickGen_i
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (sampleTick),
      .scanTick     (scanTick)
   );

   inputSampler inputSampler_i
   (
      .selected_clk (selected_clk),
      .res          (res),
      .sampleTick   (sampleTick),
      .panelRaw     (panelRaw),
      .panel        (panel)
   );

   portRegs portRegs_i
   (
      .selected_clk (selected_clk),
      .res          (res),
      .req          (req),
      .rsp          (rsp),
      .panel        (panel),
      .ports        (ports)
   );

   displayDriver displayDriver_i
   (
      .selected_clk (selected_clk),
      .res          (res),
      .scanTick     (scanTick),
      .ports        (ports),
      .panel        (panel),
      .seg          (seg),
      .an           (an)
   );

   assign leds = ports.portB[15:0];

endmodule

`default_nettype wire

// ==== bench/boardTop_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module boardTop_assertions import boardPkg::*;
(
   input logic        selected_clk,
   input logic        res,
   input apbReq       req,
   input apbRsp       rsp,
   input logic [15:0] leds,
   input logic [7:0]  seg,
   input logic [7:0]  an
);

   anOneHot: assert property (@(posedge selected_clk) disable iff (res)
      ($onehot(~an) || an == 8'hff))
   else
      $error("anode vector is neither one-hot low nor all ones");

   noWaitStates: assert property (@(posedge selected_clk) disable iff (res)
      req.psel |-> rsp.pready)
   else
      $error("pready was low during a selected transfer");

   // leds take the low half of each portB write and hold otherwise
   ledsFollowPortB: assert property (@(posedge selected_clk) disable iff (res)
      ($past(req.psel && req.penable && req.pwrite && req.paddr == portBAddr)
         ? (leds == $past(req.pwdata[15:0])) : $stable(leds)))
   else
      $error("leds differ from the low half of the last portB write");

   // dark digits carry dark segments
   darkBeforeScan: assert property (@(posedge selected_clk) disable iff (res)
      (an == 8'hff) |-> (seg == 8'hff))
   else
      $error("segments lit while no digit is selected");

   staysLit: assert property (@(posedge selected_clk) disable iff (res)
      ($past(an) != 8'hff) |-> (an != 8'hff))
   else
      $error("display went dark again after scanning started");

endmodule

bind boardTop boardTop_assertions boardTop_assertions_i
(
   .selected_clk (selected_clk),
   .res          (res),
   .req          (req),
   .rsp          (rsp),
   .leds         (leds),
   .seg          (seg),
   .an           (an)
);

`default_nettype wire

// ==== bench/boardTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module boardTop_tb import boardPkg::*;
();

   localparam int cycleLimit = 4000;
   localparam int sampleWait = sampleDivide + 4; // sync flops plus one sample period
   localparam int scanWait   = 10 * scanDivide;  // a full scan of 8 digits with margin

   // gfedcba, active high
   localparam logic [6:0] segTable [16] = '{
      7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
      7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
   };

   logic        selected_clk;
   logic        res;
   panelIn      panelRaw;
   apbReq       req;
   apbRsp       rsp;
   logic [15:0] leds;
   logic [7:0]  seg;
   logic [7:0]  an;

   integer  seed;
   int      cycleCount = 0;
   dataWord clkModel = '0; // expected clkTest
   dataWord portModel [4];

   boardTop boardTop_i
   (
      .selected_clk (selected_clk),
      .res          (res),
      .panelRaw     (panelRaw),
      .req          (req),
      .rsp          (rsp),
      .leds         (leds),
      .seg          (seg),
      .an           (an)
   );

   initial selected_clk = 1'b0;
   always #5 selected_clk = ~selected_clk;

   always @(posedge selected_clk)
   begin
      cycleCount <= cycleCount + 1;
      clkModel   <= res ? '0 : clkModel + 32'd1;
      if (cycleCount >= cycleLimit)
         stopRun("timeout, the test did not finish within the cycle limit");
   end

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkEqual(input string testName, input dataWord expected,
                             input dataWord actual);
      assert (actual == expected)
      else
         stopRun($sformatf("FAIL %s expected %h actual %h", testName, expected, actual));
   endtask

   // setup cycle, access cycle, then one idle cycle
   task automatic apbTransfer(input logic write, input addrWord addr, input dataWord wdata,
                              output dataWord rdata, output logic err,
                              output dataWord clkSeen);
      @(negedge selected_clk);
      req.psel    = 1'b1;
      req.penable = 1'b0;
      req.pwrite  = write;
      req.paddr   = addr;
      req.pwdata  = wdata;
      @(negedge selected_clk);
      req.penable = 1'b1;
      #2;
      rdata   = rsp.prdata;
      err     = rsp.pslverr;
      clkSeen = clkModel;
      @(negedge selected_clk);
      req.psel    = 1'b0;
      req.penable = 1'b0;
   endtask

   task automatic writeReg(input string testName, input addrWord addr, input dataWord data,
                           input logic expectErr);
      dataWord rdata;
      logic    err;
      dataWord clkSeen;
      apbTransfer(1'b1, addr, data, rdata, err, clkSeen);
      checkEqual({testName, " pslverr"}, 32'(expectErr), 32'(err));
      if (!expectErr)
         portModel[addr[1:0]] = data;
   endtask

   task automatic readReg(input string testName, input addrWord addr, input logic expectErr,
                          output dataWord data, output dataWord clkSeen);
      logic err;
      apbTransfer(1'b0, addr, '0, data, err, clkSeen);
      checkEqual({testName, " pslverr"}, 32'(expectErr), 32'(err));
   endtask

   task automatic checkPorts(input string testName);
      dataWord data;
      dataWord clkSeen;
      addrWord addr;
      addr = portAAddr;
      repeat (4)
      begin
         readReg(testName, addr, 1'b0, data, clkSeen);
         checkEqual($sformatf("%s port %0d", testName, addr), portModel[addr[1:0]], data);
         addr = addr + 4'd1;
      end
   endtask

   task automatic setPanel(input panelIn value);
      @(negedge selected_clk);
      panelRaw = value;
      repeat (sampleWait) @(negedge selected_clk); // past the sampler's worst latency
   endtask

   // the five button bits in struct order, zero-extended
   function automatic dataWord expectButtons(input panelIn p);
      dataWord w;
      w      = '0;
      w[4:0] = {p.btnC, p.btnU, p.btnD, p.btnL, p.btnR};
      return w;
   endfunction

   function automatic dataWord displayModel(input panelIn p, input dataWord clkValue);
      dataWord w;
      case (p.switches[11:8])
         4'd0:    w = portModel[0];
         4'd1:    w = portModel[1];
         4'd2:    w = portModel[2];
         4'd3:    w = portModel[3];
         4'd4:    w = clkValue;
         4'd5:    w = expectButtons(p);
         4'd6:    w = 32'(p.switches);
         default: w = '0;
      endcase
      return w;
   endfunction

   function automatic logic [2:0] digitOf(input logic [7:0] anodes);
      logic [2:0] k;
      logic [2:0] j;
      k = 3'd0;
      j = 3'd0;
      repeat (8)
      begin
         if (!anodes[j])
            k = j;
         j = j + 3'd1;
      end
      return k;
   endfunction

   task automatic watchScan(input string testName);
      logic [7:0] prevAn;
      logic [7:0] seen;
      logic [2:0] k;
      dataWord    word;
      int         waited;
      prevAn = an;
      seen   = '0;
      waited = 0;
      while (seen != 8'hff && waited < scanWait)
      begin
         @(negedge selected_clk);
         #2;
         if (an != prevAn && an != 8'hff)
         begin
            k    = digitOf(an);
            word = displayModel(panelRaw, clkModel - 32'd1); // loaded one edge ago
            checkEqual($sformatf("%s digit %0d", testName, k),
                       32'({1'b1, ~segTable[word[{k, 2'b00} +: 4]]}), 32'(seg));
            seen[k] = 1'b1;
         end
         prevAn = an;
         waited++;
      end
      checkEqual({testName, " digits shown"}, 32'hff, 32'(seen));
   endtask

   initial
   begin
      dataWord rdata;
      dataWord rnd;
      dataWord val1;
      dataWord val2;
      dataWord val3;
      dataWord stamp1;
      dataWord stamp2;
      dataWord stamp3;
      panelIn  pv;
      addrWord addr;
      selCode  sel;
      seed     = 32'ha96b;
      res      = 1'b1;
      panelRaw = '0;
      req      = '0;
      portModel[0] = '0;
      portModel[1] = '0;
      portModel[2] = '0;
      portModel[3] = '0;
      repeat (4) @(negedge selected_clk);
      res = 1'b0;

      // display stays dark until the first scan tick
      repeat (3)
      begin
         #2;
         checkEqual("reset an", 32'hff, 32'(an));
         checkEqual("reset seg", 32'hff, 32'(seg));
         checkEqual("reset leds", 32'd0, 32'(leds));
         checkEqual("reset pslverr", 32'd0, 32'(rsp.pslverr));
         @(negedge selected_clk);
      end
      readReg("reset portA", portAAddr, 1'b0, rdata, stamp1);
      checkEqual("reset portA", 32'd0, rdata);

      repeat (2)
      begin
         addr = portAAddr;
         repeat (4)
         begin
            rnd = $random(seed);
            writeReg("port write", addr, rnd, 1'b0);
            addr = addr + 4'd1;
         end
         checkPorts("port readback");
         checkEqual("leds", 32'(portModel[1][15:0]), 32'(leds));
      end

      readReg("clkTest first", clkTestAddr, 1'b0, val1, stamp1);
      repeat (7) @(negedge selected_clk);
      readReg("clkTest second", clkTestAddr, 1'b0, val2, stamp2);
      checkEqual("clkTest distance", stamp2 - stamp1, val2 - val1);
      rnd = $random(seed);
      writeReg("clkTest write", clkTestAddr, rnd, 1'b1);
      readReg("clkTest third", clkTestAddr, 1'b0, val3, stamp3);
      checkEqual("clkTest after write", stamp3 - stamp1, val3 - val1);

      addr = 4'd7;
      repeat (9)
      begin
         readReg("bad address read", addr, 1'b1, rdata, stamp1);
         rnd = $random(seed);
         writeReg("bad address write", addr, rnd, 1'b1);
         addr = addr + 4'd1;
      end
      writeReg("portI write", portIAddr, rnd, 1'b1);
      writeReg("portJ write", portJAddr, rnd, 1'b1);
      checkPorts("ports after errors");

      repeat (2)
      begin
         rnd = $random(seed);
         pv  = rnd[20:0];
         setPanel(pv);
         readReg("portI", portIAddr, 1'b0, rdata, stamp1);
         checkEqual("portI buttons", expectButtons(pv), rdata);
         readReg("portJ", portJAddr, 1'b0, rdata, stamp1);
         checkEqual("portJ switches", 32'(pv.switches), rdata);
      end

      sel = 4'd0;
      repeat (7)
      begin
         rnd = $random(seed);
         pv  = rnd[20:0];
         pv.switches[11:8] = sel;
         setPanel(pv);
         watchScan($sformatf("display select %0d", sel));
         sel = sel + 4'd1;
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
common/boardPkg.sv
logic/tickGen.sv
logic/inputSampler.sv
ports/portRegs.sv
display/displayDriver.sv
logic/boardTop.sv
bench/boardTop_assertions.sv
bench/boardTop_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the board testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module boardTop_tb -Mdir obj_dir -f compile.f
./obj_dir/VboardTop_tb
